//--- Makefile
# Verilator lint and simulation of the LED&KEY driver testbench

VERILATOR ?= verilator
TOP       ?= led_key_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/tm1638_defines.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

# the log decides, not the simulator exit status
sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/led_key_refresh.sv
// refresh sequencer: sends the TM1638 setup sequence, then rebuilds the display frame on register changes
`include "tm1638_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module led_key_refresh (
	input  wire                       i_clk,
	input  wire                       i_arst_n,
	input  wire                       i_changed,
	input  wire tm1638_pkg::byte_t    i_rd_data,
	input  wire                       i_tx_ready,
	input  wire                       i_shift_idle,
	output logic                      o_rd_en,
	output tm1638_pkg::reg_adr_t      o_rd_adr,
	output logic                      o_tx_valid,
	output tm1638_pkg::byte_t         o_tx_data,
	output logic                      o_tx_first,
	output logic                      o_tx_last,
	output logic                      o_idle
);

	typedef enum logic [4:0] {
		S_RESET, S_BOOT_INC, S_BOOT_ADR, S_BOOT_ZERO,
		S_IDLE, S_FETCH_LED, S_WAIT_LED, S_SAVE_LED,
		S_FETCH_BRT, S_WAIT_BRT, S_SAVE_BRT, S_SEND_ADR,
		S_FETCH_DIG, S_WAIT_DIG, S_SEND_DIG, S_SEND_LED,
		S_SEND_ON
	} state_t;

	state_t                  state_q;
	tm1638_pkg::byte_t       led_q;
	tm1638_pkg::bright_t     bright_q;
	tm1638_pkg::digit_idx_t  dig_q;
	logic [3:0]              zero_q; // zero byte count during setup
	logic                    pend_q;
	logic                    hs;
	logic                    start;

	assign hs     = o_tx_valid && i_tx_ready;
	assign start  = (state_q == S_IDLE) && pend_q && i_shift_idle;
	assign o_idle = (state_q == S_IDLE) && !pend_q && i_shift_idle;

	// read requests and byte stream decoded from state
	always_comb begin
		o_rd_en    = 1'b0;
		o_rd_adr   = '0;
		o_tx_valid = 1'b0;
		o_tx_data  = '0;
		o_tx_first = 1'b0;
		o_tx_last  = 1'b0;
		case (state_q)
			S_FETCH_LED: begin
				o_rd_en  = 1'b1;
				o_rd_adr = `REG_LED_ADR;
			end
			S_FETCH_BRT: begin
				o_rd_en  = 1'b1;
				o_rd_adr = `REG_BRIGHT_ADR;
			end
			S_FETCH_DIG: begin
				o_rd_en  = 1'b1;
				o_rd_adr = {1'b0, dig_q};
			end
			S_BOOT_INC: begin
				o_tx_valid = 1'b1;
				o_tx_data  = `TM_CMD_AUTO_INC;
				o_tx_first = 1'b1;
				o_tx_last  = 1'b1;
			end
			S_BOOT_ADR, S_SEND_ADR: begin
				o_tx_valid = 1'b1;
				o_tx_data  = `TM_CMD_ADDR0;
				o_tx_first = 1'b1;
			end
			S_BOOT_ZERO: begin
				o_tx_valid = 1'b1; // data stays zero
				o_tx_last  = (zero_q == 4'(`TM_FRAME_BYTES - 2));
			end
			S_SEND_DIG: begin
				o_tx_valid = 1'b1;
				o_tx_data  = i_rd_data; // held by the bank until the next read
			end
			S_SEND_LED: begin
				o_tx_valid = 1'b1;
				o_tx_data  = {7'd0, led_q[dig_q]};
				o_tx_last  = (dig_q == 3'(`TM_NUM_DIGITS - 1));
			end
			S_SEND_ON: begin
				o_tx_valid = 1'b1;
				o_tx_data  = `TM_CMD_DISPLAY_ON + {5'd0, bright_q};
				o_tx_first = 1'b1;
				o_tx_last  = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q  <= S_RESET;
			dig_q    <= '0;
			zero_q   <= '0;
			bright_q <= '0; // setup sends display-on at level 0
		end else begin
			case (state_q)
				S_RESET:     if (i_shift_idle) state_q <= S_BOOT_INC;
				S_BOOT_INC:  if (hs) state_q <= S_BOOT_ADR;
				S_BOOT_ADR: begin
					if (hs) begin
						zero_q  <= '0;
						state_q <= S_BOOT_ZERO;
					end
				end
				S_BOOT_ZERO: begin
					if (hs) begin
						zero_q <= zero_q + 4'd1;
						if (o_tx_last)
							state_q <= S_SEND_ON;
					end
				end
				S_IDLE:      if (start) state_q <= S_FETCH_LED;
				S_FETCH_LED: state_q <= S_WAIT_LED;
				S_WAIT_LED:  state_q <= S_SAVE_LED;
				S_SAVE_LED:  state_q <= S_FETCH_BRT;
				S_FETCH_BRT: state_q <= S_WAIT_BRT;
				S_WAIT_BRT:  state_q <= S_SAVE_BRT;
				S_SAVE_BRT: begin
					bright_q <= i_rd_data[2:0];
					dig_q    <= '0;
					state_q  <= S_SEND_ADR;
				end
				S_SEND_ADR:  if (hs) state_q <= S_FETCH_DIG;
				S_FETCH_DIG: state_q <= S_WAIT_DIG;
				S_WAIT_DIG:  state_q <= S_SEND_DIG;
				S_SEND_DIG:  if (hs) state_q <= S_SEND_LED;
				S_SEND_LED: begin
					if (hs) begin
						dig_q   <= dig_q + 3'd1;
						state_q <= o_tx_last ? S_SEND_ON : S_FETCH_DIG;
					end
				end
				S_SEND_ON:   if (hs) state_q <= S_IDLE;
				default:     state_q <= S_RESET;
			endcase
		end
	end

	// saved LED byte for the frame
	always_ff @(posedge i_clk) begin
		if (state_q == S_SAVE_LED)
			led_q <= i_rd_data;
	end

	// changes merge into one pending refresh
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			pend_q <= 1'b0;
		else
			pend_q <= i_changed || (pend_q && !start);
	end

endmodule

`default_nettype wire

//--- hw/led_key_regs.sv
// register bank for the LED&KEY board, written by the host over Wishbone and read by the sequencer
`include "tm1638_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module led_key_regs (
	input  wire                   i_clk,
	input  wire                   i_arst_n,

	// wishbone classic slave
	input  wire                   i_wb_cyc,
	input  wire                   i_wb_stb,
	input  wire                   i_wb_we,
	input  wire tm1638_pkg::reg_adr_t i_wb_adr,
	input  wire tm1638_pkg::byte_t    i_wb_dat,
	output tm1638_pkg::byte_t     o_wb_dat,
	output logic                  o_wb_ack,

	// sequencer read port, data two edges after i_rd_en
	input  wire                   i_rd_en,
	input  wire tm1638_pkg::reg_adr_t i_rd_adr,
	output tm1638_pkg::byte_t     o_rd_data,

	output logic                  o_changed // one pulse per accepted mapped write
);

	tm1638_pkg::byte_t    digit_q [`TM_NUM_DIGITS];
	tm1638_pkg::byte_t    led_q;
	tm1638_pkg::bright_t  bright_q;

	tm1638_pkg::reg_adr_t rd_adr_q;
	logic                 rd_en_q;

	logic                 wb_acc;
	logic                 wb_map;

	// shared read mux, unmapped addresses return zero
	function automatic tm1638_pkg::byte_t read_reg(input tm1638_pkg::reg_adr_t adr);
		tm1638_pkg::byte_t val;
		if (!adr[3])
			val = digit_q[adr[2:0]];
		else if (adr == `REG_LED_ADR)
			val = led_q;
		else if (adr == `REG_BRIGHT_ADR)
			val = {5'd0, bright_q}; // zero-extended
		else
			val = '0;
		return val;
	endfunction

	assign wb_acc = i_wb_cyc && i_wb_stb && !o_wb_ack; // new cycle, not the ack beat
	assign wb_map = (i_wb_adr <= `REG_BRIGHT_ADR);

	// register writes
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `TM_NUM_DIGITS; i++) begin
				digit_q[i] <= '0;
			end
			led_q    <= '0;
			bright_q <= '0;
		end else if (wb_acc && i_wb_we) begin
			if (!i_wb_adr[3])
				digit_q[i_wb_adr[2:0]] <= i_wb_dat;
			else if (i_wb_adr == `REG_LED_ADR)
				led_q <= i_wb_dat;
			else if (i_wb_adr == `REG_BRIGHT_ADR)
				bright_q <= i_wb_dat[2:0]; // only 3 bits kept
		end
	end

	// ack and change strobe
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_ack  <= 1'b0;
			o_changed <= 1'b0;
			rd_en_q   <= 1'b0;
		end else begin
			o_wb_ack  <= wb_acc;
			o_changed <= wb_acc && i_wb_we && wb_map;
			rd_en_q   <= i_rd_en;
		end
	end

	// host read data, valid with ack
	always_ff @(posedge i_clk) begin
		if (wb_acc)
			o_wb_dat <= read_reg(i_wb_adr);
	end

	// sequencer path: latch address, then data
	always_ff @(posedge i_clk) begin
		if (i_rd_en)
			rd_adr_q <= i_rd_adr;
		if (rd_en_q)
			o_rd_data <= read_reg(rd_adr_q);
	end

endmodule

`default_nettype wire

//--- hw/led_key_top.sv
// top level of the LED&KEY driver: Wishbone register bank, refresh sequencer and TM1638 shifter
`default_nettype none
`timescale 1ns/1ps

module led_key_top (
	input  wire                       i_clk,
	input  wire                       i_arst_n,
	input  wire                       i_wb_cyc,
	input  wire                       i_wb_stb,
	input  wire                       i_wb_we,
	input  wire tm1638_pkg::reg_adr_t i_wb_adr,
	input  wire tm1638_pkg::byte_t    i_wb_dat,
	output tm1638_pkg::byte_t         o_wb_dat,
	output logic                      o_wb_ack,
	output logic                      o_tm1638_clk,
	output logic                      o_tm1638_stb,
	output logic                      o_tm1638_data,
	output logic                      o_idle
);

	// register bank to sequencer
	logic                 rd_en;
	tm1638_pkg::reg_adr_t rd_adr;
	tm1638_pkg::byte_t    rd_data;
	logic                 changed;

	// sequencer to shifter
	logic                 tx_valid;
	logic                 tx_ready;
	tm1638_pkg::byte_t    tx_data;
	logic                 tx_first;
	logic                 tx_last;
	logic                 shift_idle;

	led_key_regs u_regs (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.i_wb_we   (i_wb_we),
		.i_wb_adr  (i_wb_adr),
		.i_wb_dat  (i_wb_dat),
		.o_wb_dat  (o_wb_dat),
		.o_wb_ack  (o_wb_ack),
		.i_rd_en   (rd_en),
		.i_rd_adr  (rd_adr),
		.o_rd_data (rd_data),
		.o_changed (changed)
	);

	led_key_refresh u_refresh (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_changed    (changed),
		.i_rd_data    (rd_data),
		.i_tx_ready   (tx_ready),
		.i_shift_idle (shift_idle),
		.o_rd_en      (rd_en),
		.o_rd_adr     (rd_adr),
		.o_tx_valid   (tx_valid),
		.o_tx_data    (tx_data),
		.o_tx_first   (tx_first),
		.o_tx_last    (tx_last),
		.o_idle       (o_idle)
	);

	tm1638_serial u_serial (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_tx_valid    (tx_valid),
		.i_tx_data     (tx_data),
		.i_tx_first    (tx_first),
		.i_tx_last     (tx_last),
		.o_tx_ready    (tx_ready),
		.o_shift_idle  (shift_idle),
		.o_tm1638_clk  (o_tm1638_clk),
		.o_tm1638_stb  (o_tm1638_stb),
		.o_tm1638_data (o_tm1638_data)
	);

endmodule

`default_nettype wire

//--- hw/tm1638_defines.svh
// TM1638 command bytes, register map and serial timing; include in RTL that needs them
`ifndef TM1638_DEFINES_SVH
`define TM1638_DEFINES_SVH

`default_nettype none

// chip commands
`define TM_CMD_AUTO_INC   8'h40 // data command, auto-increment writes
`define TM_CMD_ADDR0      8'hC0 // address command, display address 0
`define TM_CMD_DISPLAY_ON 8'h88 // display on, brightness in low 3 bits

// board geometry
`define TM_NUM_DIGITS  8
`define TM_FRAME_BYTES 17 // address command + 16 data bytes

// register map
`define REG_LED_ADR    4'd8
`define REG_BRIGHT_ADR 4'd9

// system clocks per half period of the TM1638 clock
`define TM_HALF_PERIOD 4

`default_nettype wire

`endif

//--- hw/tm1638_pkg.sv
// shared vector types for the LED&KEY design and its testbench, referenced as tm1638_pkg::name

`default_nettype none

package tm1638_pkg;

	// segment pattern, command byte or host data word
	typedef logic [7:0] byte_t;

	// register address on host and internal read ports
	typedef logic [3:0] reg_adr_t;

	// digit or LED position 0..7
	typedef logic [2:0] digit_idx_t;

	// display brightness 0..7
	typedef logic [2:0] bright_t;

endpackage

`default_nettype wire

//--- hw/tm1638_serial.sv
// serial shifter: turns a valid/ready byte stream into TM1638 clock, strobe and data pins, LSB first
`include "tm1638_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module tm1638_serial (
	input  wire                    i_clk,
	input  wire                    i_arst_n,
	input  wire                    i_tx_valid,
	input  wire tm1638_pkg::byte_t i_tx_data,
	input  wire                    i_tx_first,
	input  wire                    i_tx_last,
	output logic                   o_tx_ready,
	output logic                   o_shift_idle,
	output logic                   o_tm1638_clk,
	output logic                   o_tm1638_stb,
	output logic                   o_tm1638_data
);

	localparam int HALF = `TM_HALF_PERIOD;

	typedef enum logic [2:0] {
		S_IDLE, S_LEAD, S_LOW, S_HIGH, S_HOLD, S_TAIL, S_GAP
	} state_t;

	state_t            state_q;
	logic [7:0]        half_q;  // half-period down counter
	logic [2:0]        bit_q;
	tm1638_pkg::byte_t sh_q;
	logic              last_q;
	logic              half_done;
	logic              accept;

	assign half_done    = (half_q == 8'd0);
	assign o_tx_ready   = (state_q == S_IDLE) || (state_q == S_HOLD);
	assign accept       = i_tx_valid && o_tx_ready;
	assign o_shift_idle = (state_q == S_IDLE) && o_tm1638_stb;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q       <= S_IDLE;
			half_q        <= '0;
			bit_q         <= '0;
			last_q        <= 1'b0;
			o_tm1638_clk  <= 1'b1;
			o_tm1638_stb  <= 1'b1;
			o_tm1638_data <= 1'b1;
		end else begin
			if (!half_done)
				half_q <= half_q - 8'd1;
			case (state_q)
				S_IDLE, S_HOLD: begin
					if (accept) begin
						last_q <= i_tx_last;
						bit_q  <= '0;
						half_q <= 8'(HALF - 1);
						if (i_tx_first && state_q == S_IDLE) begin
							o_tm1638_stb <= 1'b0; // lead-in before first bit
							state_q      <= S_LEAD;
						end else begin
							o_tm1638_clk  <= 1'b0;
							o_tm1638_data <= i_tx_data[0];
							state_q       <= S_LOW;
						end
					end
				end
				S_LEAD: begin
					if (half_done) begin
						o_tm1638_clk  <= 1'b0;
						o_tm1638_data <= sh_q[0];
						half_q        <= 8'(HALF - 1);
						state_q       <= S_LOW;
					end
				end
				S_LOW: begin
					if (half_done) begin
						o_tm1638_clk <= 1'b1; // chip samples here
						half_q       <= 8'(HALF - 1);
						state_q      <= S_HIGH;
					end
				end
				S_HIGH: begin
					if (half_done) begin
						half_q <= 8'(HALF - 1);
						if (bit_q == 3'd7) begin
							state_q <= last_q ? S_TAIL : S_HOLD;
						end else begin
							bit_q         <= bit_q + 3'd1;
							o_tm1638_clk  <= 1'b0;
							o_tm1638_data <= sh_q[1];
							state_q       <= S_LOW;
						end
					end
				end
				S_TAIL: begin
					if (half_done) begin
						o_tm1638_stb <= 1'b1; // end of transfer
						half_q       <= 8'(HALF - 1);
						state_q      <= S_GAP;
					end
				end
				S_GAP:   if (half_done) state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// shift register, next bit moves into position 0
	always_ff @(posedge i_clk) begin
		if (accept)
			sh_q <= i_tx_data;
		else if (state_q == S_HIGH && half_done)
			sh_q <= sh_q >> 1;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/tm1638_pkg.sv
hw/led_key_regs.sv
hw/led_key_refresh.sv
hw/tm1638_serial.sv
hw/led_key_top.sv
tb/led_key_assertions.sv
tb/led_key_tb.sv

//--- tb/led_key_assertions.sv
// concurrent checks on TM1638 pins, Wishbone ack and the byte handshake, bound into led_key_top
`default_nettype none
`timescale 1ns/1ps

module led_key_assertions (
	input wire i_clk,
	input wire i_arst_n,
	input wire i_wb_ack,
	input wire i_tm_clk,
	input wire i_tm_stb,
	input wire i_tx_valid,
	input wire i_tx_ready
);

	int fail_cnt = 0; // assertion failures so far

	ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_wb_ack |=> !i_wb_ack)
		else begin
			$error("wishbone ack held for more than one cycle");
			fail_cnt++;
		end

	// clock only moves inside a transfer
	clk_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_tm_stb && $past(i_tm_stb)) |-> $stable(i_tm_clk))
		else begin
			$error("TM1638 clock toggled while strobe was high");
			fail_cnt++;
		end

	tx_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_tx_valid && !i_tx_ready) |=> i_tx_valid) // byte waits for ready
		else begin
			$error("tx_valid dropped before the shifter took the byte");
			fail_cnt++;
		end

	reset_pins: assert property (@(posedge i_clk)
		$rose(i_arst_n) |-> (i_tm_stb && i_tm_clk))
		else begin
			$error("TM1638 strobe or clock low on reset release");
			fail_cnt++;
		end

endmodule

bind led_key_top led_key_assertions u_assertions (
	.i_clk      (i_clk),
	.i_arst_n   (i_arst_n),
	.i_wb_ack   (o_wb_ack),
	.i_tm_clk   (o_tm1638_clk),
	.i_tm_stb   (o_tm1638_stb),
	.i_tx_valid (tx_valid),
	.i_tx_ready (tx_ready)
);

`default_nettype wire

//--- tb/led_key_tb.sv
// testbench for the LED&KEY driver: Wishbone stimulus table, TM1638 pin decoder and frame checks
`include "tm1638_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module led_key_tb;

	localparam int NUM_TESTS    = 5;
	localparam int MAX_WR       = 8;
	localparam int ACK_TIMEOUT  = 16;
	localparam int IDLE_TIMEOUT = 20000;

	typedef tm1638_pkg::byte_t frame_t [`TM_FRAME_BYTES];

	logic                 i_clk;
	logic                 i_arst_n;
	logic                 i_wb_cyc;
	logic                 i_wb_stb;
	logic                 i_wb_we;
	tm1638_pkg::reg_adr_t i_wb_adr;
	tm1638_pkg::byte_t    i_wb_dat;
	tm1638_pkg::byte_t    o_wb_dat;
	logic                 o_wb_ack;
	logic                 o_tm1638_clk;
	logic                 o_tm1638_stb;
	logic                 o_tm1638_data;
	logic                 o_idle;

	tm1638_pkg::byte_t    xfer_data [$]; // decoded bytes, all transfers back to back
	int                   xfer_len [$];
	string                t_name [NUM_TESTS];
	int                   t_nwr [NUM_TESTS];
	tm1638_pkg::reg_adr_t t_adr [NUM_TESTS][MAX_WR];
	tm1638_pkg::byte_t    t_dat [NUM_TESTS][MAX_WR];
	int                   t_max_xfer [NUM_TESTS]; // 0 means no refresh allowed
	tm1638_pkg::byte_t    m_digit [`TM_NUM_DIGITS];
	tm1638_pkg::byte_t    m_led;
	tm1638_pkg::bright_t  m_bright;
	int                   errors;
	int                   n_pass;
	int                   n_fail;
	logic                 mon_clk_q = 1'b1;
	logic                 mon_stb_q = 1'b1;
	tm1638_pkg::byte_t    mon_sh;
	int                   mon_bits = 0;
	int                   mon_len = 0;
	frame_t               mon_buf;

	led_key_top UUT (
		.i_clk (i_clk), .i_arst_n (i_arst_n),
		.i_wb_cyc (i_wb_cyc), .i_wb_stb (i_wb_stb), .i_wb_we (i_wb_we),
		.i_wb_adr (i_wb_adr), .i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat), .o_wb_ack (o_wb_ack),
		.o_tm1638_clk (o_tm1638_clk), .o_tm1638_stb (o_tm1638_stb),
		.o_tm1638_data (o_tm1638_data), .o_idle (o_idle)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	// pin decoder, data taken on each rising TM1638 clock while strobe is low
	always @(posedge i_clk) begin
		int i;
		if (!i_arst_n) begin // pins settle to their reset levels
			mon_clk_q = 1'b1;
			mon_stb_q = 1'b1;
			mon_len   = 0;
			mon_bits  = 0;
		end else begin
			if (!o_tm1638_stb && o_tm1638_clk && !mon_clk_q) begin
				mon_sh = {o_tm1638_data, mon_sh[7:1]}; // LSB first
				mon_bits++;
				if (mon_bits == 8) begin
					if (mon_len < `TM_FRAME_BYTES)
						mon_buf[mon_len] = mon_sh;
					mon_len++;
					mon_bits = 0;
				end
			end
			if (o_tm1638_stb && !mon_stb_q) begin // transfer closed
				xfer_len.push_back(mon_len);
				for (i = 0; i < mon_len && i < `TM_FRAME_BYTES; i++)
					xfer_data.push_back(mon_buf[i]);
				mon_len  = 0;
				mon_bits = 0;
			end
			mon_clk_q = o_tm1638_clk;
			mon_stb_q = o_tm1638_stb;
		end
	end

	task automatic check_byte(input string name, input tm1638_pkg::byte_t exp_b,
			input tm1638_pkg::byte_t got_b);
		if (got_b !== exp_b) begin
			$display("error: %s expected %02h actual %02h", name, exp_b, got_b);
			errors++;
		end
	endtask

	task automatic check_frame(input string name, input int exp_len, input frame_t exp_f,
			input int got_len, input frame_t got_f);
		int i;
		if (got_len != exp_len) begin
			$display("error: %s length expected %0d actual %0d", name, exp_len, got_len);
			errors++;
		end else begin
			for (i = 0; i < exp_len; i++)
				check_byte($sformatf("%s byte %0d", name, i), exp_f[i], got_f[i]);
		end
	endtask

	task automatic check_ack(input string name, input string what, input logic got, input int lim);
		if (!got) begin
			$display("%s: timed out waiting for %s after %0d cycles", name, what, lim);
			errors++;
		end
	endtask

	task automatic wb_access(input string name, input logic we, input tm1638_pkg::reg_adr_t adr,
			input tm1638_pkg::byte_t dat, output tm1638_pkg::byte_t rdat);
		int   n;
		logic got;
		got  = 1'b0;
		rdat = '0;
		@(posedge i_clk);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we  <= we;
		i_wb_adr <= adr;
		i_wb_dat <= dat;
		for (n = 0; n < ACK_TIMEOUT && !got; n++) begin
			@(posedge i_clk);
			if (o_wb_ack) begin
				got  = 1'b1;
				rdat = o_wb_dat; // valid with ack
			end
		end
		i_wb_cyc <= 1'b0;
		i_wb_stb <= 1'b0;
		i_wb_we  <= 1'b0;
		check_ack(name, "Wishbone ack", got, ACK_TIMEOUT);
	endtask

	task automatic wait_idle(input string name);
		int   n;
		logic got;
		got = 1'b0;
		repeat (3) @(posedge i_clk); // change pulse reaches the sequencer
		for (n = 0; n < IDLE_TIMEOUT && !got; n++) begin
			@(posedge i_clk);
			got = o_idle;
		end
		check_ack(name, "o_idle", got, IDLE_TIMEOUT);
	endtask

	task automatic pop_xfer(output int len, output frame_t f);
		int i;
		f   = '{default: '0};
		len = xfer_len.pop_front();
		for (i = 0; i < len && i < `TM_FRAME_BYTES; i++)
			f[i] = xfer_data.pop_front();
	endtask

	task automatic apply_model(input tm1638_pkg::reg_adr_t adr, input tm1638_pkg::byte_t dat);
		if (adr < 4'd8)
			m_digit[adr[2:0]] = dat;
		else if (adr == 4'd8)
			m_led = dat;
		else if (adr == 4'd9)
			m_bright = dat[2:0];
	endtask

	function automatic tm1638_pkg::byte_t model_read(input tm1638_pkg::reg_adr_t adr);
		if (adr < 4'd8)
			return m_digit[adr[2:0]];
		if (adr == 4'd8)
			return m_led;
		return (adr == 4'd9) ? {5'd0, m_bright} : 8'h00;
	endfunction

	// last frame and display-on pair must match the model
	task automatic check_refresh(input string name, input int max_xfer);
		int     n;
		int     k;
		int     len;
		frame_t got_f;
		frame_t exp_f;
		n     = xfer_len.size();
		exp_f = '{default: '0};
		if (n > max_xfer || n % 2 != 0 || (max_xfer > 0 && n == 0)) begin
			$display("%s: saw %0d transfers, allowed up to %0d", name, n, max_xfer);
			errors++;
		end else if (n > 0) begin
			while (xfer_len.size() > 2)
				pop_xfer(len, got_f);
			exp_f[0] = `TM_CMD_ADDR0;
			for (k = 0; k < `TM_NUM_DIGITS; k++) begin
				exp_f[1 + 2 * k] = m_digit[k];
				exp_f[2 + 2 * k] = m_led[k] ? 8'h01 : 8'h00;
			end
			pop_xfer(len, got_f);
			check_frame({name, " frame"}, `TM_FRAME_BYTES, exp_f, len, got_f);
			exp_f[0] = `TM_CMD_DISPLAY_ON + {5'd0, m_bright};
			pop_xfer(len, got_f);
			check_frame({name, " display-on"}, 1, exp_f, len, got_f);
		end
		xfer_len.delete();
		xfer_data.delete();
	endtask

	task automatic report_test(input string name);
		$display("%-10s %s", name, (errors == 0) ? "ok" : "FAIL");
		if (errors == 0)
			n_pass++;
		else
			n_fail++;
	endtask

	task automatic build_table();
		tm1638_pkg::reg_adr_t burst [6] = '{4'd1, 4'd6, 4'd8, 4'd9, 4'd3, 4'd1};
		int w;
		for (w = 0; w < MAX_WR; w++) begin
			t_adr[0][w] = 4'(w); // every digit in order
			t_dat[0][w] = 8'($urandom);
			t_adr[3][w] = 4'(10 + (w % 6)); // unmapped
			t_dat[3][w] = 8'($urandom);
			t_adr[4][w] = burst[w % 6];
			t_dat[4][w] = 8'($urandom);
		end
		t_adr[1][0] = 4'd8;
		t_dat[1][0] = 8'($urandom);
		t_adr[2][0] = 4'd9;
		t_dat[2][0] = 8'($urandom) | 8'hf8; // upper bits must be dropped
		t_name     = '{"digits", "leds", "bright", "unmapped", "burst"};
		t_nwr      = '{8, 1, 1, 6, 6};
		t_max_xfer = '{4, 2, 2, 0, 4};
	endtask

	initial begin
		tm1638_pkg::byte_t rdat;
		frame_t            got_f;
		frame_t            exp_f;
		int                len;
		int                t;
		int                w;
		int                a;
		i_arst_n = 1'b0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		errors   = 0;
		n_pass   = 0;
		n_fail   = 0;
		m_digit  = '{default: '0};
		m_led    = '0;
		m_bright = '0;
		exp_f    = '{default: '0};
		void'($urandom(32'hdbc5));
		build_table();
		repeat (5) @(posedge i_clk);
		i_arst_n <= 1'b1;

		wait_idle("setup");
		if (xfer_len.size() != 3) begin
			$display("setup: saw %0d transfers instead of 3", xfer_len.size());
			errors++;
		end else begin
			exp_f[0] = `TM_CMD_AUTO_INC;
			pop_xfer(len, got_f);
			check_frame("setup auto-inc", 1, exp_f, len, got_f);
			exp_f[0] = `TM_CMD_ADDR0;
			pop_xfer(len, got_f);
			check_frame("setup frame", `TM_FRAME_BYTES, exp_f, len, got_f);
			exp_f[0] = `TM_CMD_DISPLAY_ON;
			pop_xfer(len, got_f);
			check_frame("setup display-on", 1, exp_f, len, got_f);
		end
		report_test("setup");

		for (t = 0; t < NUM_TESTS; t++) begin
			errors = 0;
			for (w = 0; w < t_nwr[t]; w++) begin
				wb_access(t_name[t], 1'b1, t_adr[t][w], t_dat[t][w], rdat);
				apply_model(t_adr[t][w], t_dat[t][w]);
			end
			wait_idle(t_name[t]);
			check_refresh(t_name[t], t_max_xfer[t]);
			for (a = 0; a < 16; a++) begin
				wb_access(t_name[t], 1'b0, 4'(a), '0, rdat);
				check_byte($sformatf("%s read %0d", t_name[t], a), model_read(4'(a)), rdat);
			end
			report_test(t_name[t]);
		end

		if (UUT.u_assertions.fail_cnt != 0) begin
			$display("protocol assertions failed %0d times", UUT.u_assertions.fail_cnt);
			n_fail++;
		end
		$display("counts: %0d ok, %0d failing", n_pass, n_fail);
		if (n_fail == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
